// ==== hw/reg_map_pkg.sv ====
/* register map package
   spi frame layout, register addresses, field widths and reset values
   of the control register bank
*/
package reg_map_pkg;

  ////////////////////
  // frame layout
  localparam int REG_WIDTH  = 32;                 // data phase / register width
  localparam int ADDR_WIDTH = 7;                  // cmd bits 6..0
  localparam int FRAME_BITS = 40;                 // cmd byte + 32 data bits
  localparam int CMD_BITS   = 8;
  localparam int CMD_WR_BIT = 7;                  // set for a write
  localparam int FRAME_CNT_BITS = 6;              // holds 0..FRAME_BITS

  localparam logic [FRAME_CNT_BITS-1:0] CMD_LAST   = FRAME_CNT_BITS'(CMD_BITS - 1);
  localparam logic [FRAME_CNT_BITS-1:0] FRAME_LAST = FRAME_CNT_BITS'(FRAME_BITS - 1);
  localparam logic [FRAME_CNT_BITS-1:0] FRAME_END  = FRAME_CNT_BITS'(FRAME_BITS);

  ////////////////////
  // addresses
  localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS    = 7'h00;  // read only
  localparam logic [ADDR_WIDTH-1:0] ADDR_MODE      = 7'h01;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DIRECT    = 7'h02;
  localparam logic [ADDR_WIDTH-1:0] ADDR_OE_4094   = 7'h03;
  localparam logic [ADDR_WIDTH-1:0] ADDR_APERTURE  = 7'h04;
  localparam logic [ADDR_WIDTH-1:0] ADDR_PRECHARGE = 7'h05;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SPI_ROUTE = 7'h06;

  // status word, magic in 7..0, flags in 10..8
  localparam logic [7:0] STATUS_MAGIC = 8'hAA;
  localparam int HW_FLAG_BITS   = 3;
  localparam int PRECHARGE_BITS = 24;             // used width of precharge count

  ////////////////////
  // reset values, full words, bank takes the slice it stores
  localparam logic [REG_WIDTH-1:0] RST_MODE      = 32'd0;
  localparam logic [REG_WIDTH-1:0] RST_DIRECT    = 32'd0;
  localparam logic [REG_WIDTH-1:0] RST_OE_4094   = 32'd0;  // 4094 outputs off at power up
  localparam logic [REG_WIDTH-1:0] RST_SPI_ROUTE = 32'd0;
  localparam logic [REG_WIDTH-1:0] RST_APERTURE  = 32'd16;
  localparam logic [REG_WIDTH-1:0] RST_PRECHARGE = 32'd8;

endpackage

// ==== hw/io_map_pkg.sv ====
/* output pin map package
   mode codes of the output mux and the layout of the 25-bit pin word
*/
package io_map_pkg;

  localparam int OUT_BITS  = 25;                  // pin word width
  localparam int MODE_BITS = 3;                   // eight modes

  ////////////////////
  // mode codes
  localparam logic [MODE_BITS-1:0] MODE_DIRECT    = 3'd0;  // follow direct register
  localparam logic [MODE_BITS-1:0] MODE_ZERO      = 3'd1;
  localparam logic [MODE_BITS-1:0] MODE_ONES      = 3'd2;
  localparam logic [MODE_BITS-1:0] MODE_PATTERN   = 3'd3;  // free running counter
  localparam logic [MODE_BITS-1:0] MODE_PRECHARGE = 3'd4;  // precharge sequencer view
  // 5..7 drive zero

  ////////////////////
  // pin word fields
  localparam int LEDS_LSB       = 0;
  localparam int LEDS_BITS      = 4;
  localparam int MONITOR_LSB    = 4;
  localparam int MONITOR_BITS   = 8;
  localparam int SPI_INT_BIT    = 12;
  localparam int MEAS_DONE_BIT  = 13;
  localparam int PC1_BIT        = 14;             // precharge switch 1
  localparam int PC2_BIT        = 15;
  localparam int U410_LSB       = 16;             // az mux
  localparam int U410_BITS      = 4;
  localparam int CMPR_LATCH_BIT = 20;             // adc comparator latch
  localparam int U902_LSB       = 21;             // adc ref current mux
  localparam int U902_BITS      = 4;

  localparam int PATTERN_BITS = 32;               // test pattern counter

endpackage

// ==== hw/spi_port.sv ====
/* spi port
   oversamples the mcu spi link (mode 0) in the clk domain, decodes
   40-bit frames, shifts read data out and routes the bus to the 4094 chain
*/
`timescale 1ns/1ns

module spi_port (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_sck,
  input  logic                              i_sdi,
  input  logic                              i_ss_n,       // register frame select
  input  logic                              i_cs2_n,      // 4094 select
  input  logic                              i_route_en,
  input  logic                              i_4094_miso,
  input  logic [reg_map_pkg::REG_WIDTH-1:0]  i_rd_data,
  output logic                              o_sdo,
  output logic [reg_map_pkg::ADDR_WIDTH-1:0] o_rd_addr,
  output logic                              o_wr_valid,
  output logic [reg_map_pkg::ADDR_WIDTH-1:0] o_wr_addr,
  output logic [reg_map_pkg::REG_WIDTH-1:0]  o_wr_data,
  output logic                              o_4094_clk,
  output logic                              o_4094_data,
  output logic                              o_4094_strobe
);

  logic [1:0] sck_sync, sdi_sync, ss_sync, cs2_sync;  // [1] is the synced copy
  logic       sck_d;
  logic       sck_rise, sck_fall;
  logic [reg_map_pkg::FRAME_CNT_BITS-1:0] bit_cnt;
  logic [reg_map_pkg::REG_WIDTH-1:0]      rx_sr, tx_sr;
  logic [reg_map_pkg::CMD_BITS-1:0]       cmd;
  logic       load_tx;                                // bank answer valid next cycle
  logic       sdo_q;
  logic       route_act;

  ////////////////////
  // pin synchronizers
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      sck_sync <= 2'b00;
      sdi_sync <= 2'b00;
      ss_sync  <= 2'b11;              // deselected
      cs2_sync <= 2'b11;
      sck_d    <= 1'b0;
    end
    else
    begin
      sck_sync <= {sck_sync[0], i_sck};
      sdi_sync <= {sdi_sync[0], i_sdi};
      ss_sync  <= {ss_sync[0], i_ss_n};
      cs2_sync <= {cs2_sync[0], i_cs2_n};
      sck_d    <= sck_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_d;
  assign sck_fall = ~sck_sync[1] & sck_d;

  ////////////////////
  // frame decode
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      bit_cnt    <= '0;
      load_tx    <= 1'b0;
      o_wr_valid <= 1'b0;
      sdo_q      <= 1'b0;
    end
    else
    begin
      o_wr_valid <= 1'b0;             // single cycle pulse
      load_tx    <= 1'b0;
      if (ss_sync[1])
      begin
        bit_cnt <= '0;                // idle or aborted frame, nothing written
        sdo_q   <= 1'b0;
      end
      else
      begin
        if (sck_rise && bit_cnt != reg_map_pkg::FRAME_END)
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == reg_map_pkg::CMD_LAST)
            load_tx <= 1'b1;
          if (bit_cnt == reg_map_pkg::FRAME_LAST && cmd[reg_map_pkg::CMD_WR_BIT])
            o_wr_valid <= 1'b1;
        end
        // mode 0, next bit goes out after the falling edge
        if (sck_fall && bit_cnt >= reg_map_pkg::CMD_BITS && bit_cnt != reg_map_pkg::FRAME_END)
          sdo_q <= tx_sr[reg_map_pkg::REG_WIDTH-1];
      end
    end
  end

  // payload shift registers
  always_ff @(posedge clk)
  begin
    if (sck_rise && !ss_sync[1])
    begin
      rx_sr <= {rx_sr[reg_map_pkg::REG_WIDTH-2:0], sdi_sync[1]};
      if (bit_cnt == reg_map_pkg::CMD_LAST)
        cmd <= {rx_sr[reg_map_pkg::CMD_BITS-2:0], sdi_sync[1]};
      if (bit_cnt == reg_map_pkg::FRAME_LAST)
        o_wr_data <= {rx_sr[reg_map_pkg::REG_WIDTH-2:0], sdi_sync[1]};
    end
    if (load_tx)
      tx_sr <= i_rd_data;             // bank answered o_rd_addr
    else if (sck_fall && !ss_sync[1] && bit_cnt >= reg_map_pkg::CMD_BITS)
      tx_sr <= {tx_sr[reg_map_pkg::REG_WIDTH-2:0], 1'b0};
  end

  assign o_rd_addr = cmd[reg_map_pkg::ADDR_WIDTH-1:0];
  assign o_wr_addr = cmd[reg_map_pkg::ADDR_WIDTH-1:0];

  ////////////////////
  // 4094 pass-through
  assign route_act     = i_route_en & ~cs2_sync[1];
  assign o_4094_clk    = route_act & sck_sync[1];
  assign o_4094_data   = route_act & sdi_sync[1];
  assign o_4094_strobe = route_act;                         // strobe hi while shifting
  assign o_sdo         = route_act ? i_4094_miso : sdo_q;   // miso mux

  // bank sees at most one write per frame
  a_wr_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wr_valid |=> !o_wr_valid);

endmodule

// ==== hw/register_bank.sv ====
/* register bank
   control registers written over spi, read mux with status word,
   drives mode, direct word, 4094 enable, routing and sequencer timing
*/
`timescale 1ns/1ns

module register_bank (
  input  logic                                  clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_wr_valid,
  input  logic [reg_map_pkg::ADDR_WIDTH-1:0]     i_wr_addr,
  input  logic [reg_map_pkg::REG_WIDTH-1:0]      i_wr_data,
  input  logic [reg_map_pkg::ADDR_WIDTH-1:0]     i_rd_addr,
  input  logic [reg_map_pkg::HW_FLAG_BITS-1:0]   i_hw_flags,
  output logic [reg_map_pkg::REG_WIDTH-1:0]      o_rd_data,
  output logic [io_map_pkg::MODE_BITS-1:0]       o_mode,
  output logic [reg_map_pkg::REG_WIDTH-1:0]      o_direct,
  output logic                                  o_4094_oe,
  output logic                                  o_route_en,
  output logic [reg_map_pkg::REG_WIDTH-1:0]      o_aperture,
  output logic [reg_map_pkg::PRECHARGE_BITS-1:0] o_precharge
);

  logic [reg_map_pkg::REG_WIDTH-1:0] status_word;

  // magic low byte, board flags above it
  assign status_word = {
    {(reg_map_pkg::REG_WIDTH - reg_map_pkg::HW_FLAG_BITS - 8){1'b0}},
    i_hw_flags,                                   // 10..8
    reg_map_pkg::STATUS_MAGIC                     // 7..0
  };

  ////////////////////
  // writes
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      o_mode      <= reg_map_pkg::RST_MODE[io_map_pkg::MODE_BITS-1:0];
      o_direct    <= reg_map_pkg::RST_DIRECT;
      o_4094_oe   <= reg_map_pkg::RST_OE_4094[0];
      o_route_en  <= reg_map_pkg::RST_SPI_ROUTE[0];
      o_aperture  <= reg_map_pkg::RST_APERTURE;
      o_precharge <= reg_map_pkg::RST_PRECHARGE[reg_map_pkg::PRECHARGE_BITS-1:0];
    end
    else if (i_wr_valid)
    begin
      case (i_wr_addr)
        reg_map_pkg::ADDR_MODE:      o_mode      <= i_wr_data[io_map_pkg::MODE_BITS-1:0];
        reg_map_pkg::ADDR_DIRECT:    o_direct    <= i_wr_data;
        reg_map_pkg::ADDR_OE_4094:   o_4094_oe   <= i_wr_data[0];
        reg_map_pkg::ADDR_SPI_ROUTE: o_route_en  <= i_wr_data[0];   // bit 0 routes cs2
        reg_map_pkg::ADDR_APERTURE:  o_aperture  <= i_wr_data;
        reg_map_pkg::ADDR_PRECHARGE:
          o_precharge <= i_wr_data[reg_map_pkg::PRECHARGE_BITS-1:0];
        default: ;                                  // status and unmapped, dropped
      endcase
    end
  end

  ////////////////////
  // reads, combinational so the port can load before the data phase
  always_comb
  begin
    case (i_rd_addr)
      reg_map_pkg::ADDR_STATUS:    o_rd_data = status_word;
      reg_map_pkg::ADDR_MODE:      o_rd_data = reg_map_pkg::REG_WIDTH'(o_mode);
      reg_map_pkg::ADDR_DIRECT:    o_rd_data = o_direct;
      reg_map_pkg::ADDR_OE_4094:   o_rd_data = reg_map_pkg::REG_WIDTH'(o_4094_oe);
      reg_map_pkg::ADDR_SPI_ROUTE: o_rd_data = reg_map_pkg::REG_WIDTH'(o_route_en);
      reg_map_pkg::ADDR_APERTURE:  o_rd_data = o_aperture;
      reg_map_pkg::ADDR_PRECHARGE: o_rd_data = reg_map_pkg::REG_WIDTH'(o_precharge);
      default:                     o_rd_data = '0;    // unmapped reads zero
    endcase
  end

  // 4094 outputs only come on through an explicit mcu write
  a_oe_by_write : assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(o_4094_oe) |-> $past(i_wr_valid && i_wr_addr == reg_map_pkg::ADDR_OE_4094));

endmodule

// ==== hw/precharge_sequencer.sv ====
/* precharge sequencer
   alternates precharge and sample phases of programmable length,
   toggles an led per full cycle and exports phase and cycle count
*/
`timescale 1ns/1ns

module precharge_sequencer (
  input  logic                                  clk,
  input  logic                                  i_rst_n,
  input  logic [reg_map_pkg::REG_WIDTH-1:0]      i_aperture,   // sample length
  input  logic [reg_map_pkg::PRECHARGE_BITS-1:0] i_precharge,  // precharge length
  output logic                                  o_pc_sw,
  output logic                                  o_led,
  output logic [io_map_pkg::MONITOR_BITS-1:0]    o_monitor
);

  logic [reg_map_pkg::REG_WIDTH-1:0]    cnt_q;       // cycles left in phase, minus one
  logic [reg_map_pkg::REG_WIDTH-1:0]    load_q;      // value loaded at phase start
  logic [reg_map_pkg::REG_WIDTH-1:0]    pc_ext;
  logic [reg_map_pkg::REG_WIDTH-1:0]    pc_len_m1, ap_len_m1, next_len_m1;
  logic                                 phase_q;     // 1 = precharge
  logic [io_map_pkg::MONITOR_BITS-2:0]  cycle_q;     // full cycles, mod 128

  assign pc_ext = reg_map_pkg::REG_WIDTH'(i_precharge);

  // zero length runs as one cycle
  assign pc_len_m1 = (pc_ext == '0) ? '0 : pc_ext - 32'd1;
  assign ap_len_m1 = (i_aperture == '0) ? '0 : i_aperture - 32'd1;
  assign next_len_m1 = phase_q ? ap_len_m1 : pc_len_m1;  // length of the phase after this

  ////////////////////
  // phase counter
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      phase_q <= 1'b1;                                 // start in precharge
      cnt_q   <= reg_map_pkg::RST_PRECHARGE - 32'd1;   // bank reset count
      load_q  <= reg_map_pkg::RST_PRECHARGE - 32'd1;
      o_led   <= 1'b0;
      cycle_q <= '0;
    end
    else if (cnt_q == '0)
    begin
      phase_q <= ~phase_q;
      cnt_q   <= next_len_m1;
      load_q  <= next_len_m1;
      if (!phase_q)                  // end of sample closes a full cycle
      begin
        o_led   <= ~o_led;
        cycle_q <= cycle_q + 1'b1;
      end
    end
    else
      cnt_q <= cnt_q - 32'd1;
  end

  assign o_pc_sw   = phase_q;                     // switch closed during precharge
  assign o_monitor = {phase_q, cycle_q};

  a_cnt_bound : assert property (@(posedge clk) disable iff (!i_rst_n)
    cnt_q <= load_q);

endmodule

// ==== hw/output_mux.sv ====
/* output mux
   free running test pattern counter and registered eight-way selection
   of the 25-bit pin word by mode
*/
`timescale 1ns/1ns

module output_mux (
  input  logic                               clk,
  input  logic                               i_rst_n,
  input  logic [io_map_pkg::MODE_BITS-1:0]    i_mode,
  input  logic [reg_map_pkg::REG_WIDTH-1:0]   i_direct,
  input  logic                               i_pc_sw,
  input  logic                               i_pc_led,
  input  logic [io_map_pkg::MONITOR_BITS-1:0] i_pc_monitor,
  output logic [io_map_pkg::OUT_BITS-1:0]     o_word
);

  logic [io_map_pkg::PATTERN_BITS-1:0] pattern_q;
  logic [io_map_pkg::OUT_BITS-1:0]     sel_word;

  // test pattern, one count per clk
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + io_map_pkg::PATTERN_BITS'(1);
  end

  ////////////////////
  // mode select
  always_comb
  begin
    sel_word = '0;                                            // modes 5..7
    case (i_mode)
      io_map_pkg::MODE_DIRECT:  sel_word = i_direct[io_map_pkg::OUT_BITS-1:0];
      io_map_pkg::MODE_ZERO:    sel_word = '0;
      io_map_pkg::MODE_ONES:    sel_word = '1;
      io_map_pkg::MODE_PATTERN: sel_word = pattern_q[io_map_pkg::OUT_BITS-1:0];
      io_map_pkg::MODE_PRECHARGE:
      begin
        // led0, monitor and pc1 only, rest held low
        sel_word[io_map_pkg::LEDS_LSB] = i_pc_led;
        sel_word[io_map_pkg::MONITOR_LSB +: io_map_pkg::MONITOR_BITS] = i_pc_monitor;
        sel_word[io_map_pkg::PC1_BIT] = i_pc_sw;
      end
      default:                  sel_word = '0;
    endcase
  end

  // registered pins, one cycle behind mode/source
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_word <= '0;
    else
      o_word <= sel_word;
  end

endmodule

// ==== hw/meas_ctrl_top.sv ====
/* measurement control top
   spi port, register bank, precharge sequencer and output mux,
   pin word split out to the board signals
*/
`timescale 1ns/1ns

module meas_ctrl_top (
  input  logic                                clk,
  input  logic                                i_rst_n,
  input  logic                                i_sck,
  input  logic                                i_sdi,
  input  logic                                i_ss_n,
  input  logic                                i_cs2_n,
  input  logic                                i_4094_miso,
  input  logic [reg_map_pkg::HW_FLAG_BITS-1:0] i_hw_flags,
  output logic                                o_sdo,
  output logic                                o_4094_clk,
  output logic                                o_4094_data,
  output logic                                o_4094_strobe,
  output logic                                o_4094_oe,
  output logic [io_map_pkg::LEDS_BITS-1:0]     o_leds,
  output logic [io_map_pkg::MONITOR_BITS-1:0]  o_monitor,
  output logic                                o_spi_interrupt,
  output logic                                o_meas_complete,
  output logic                                o_sig_pc1_sw,
  output logic                                o_sig_pc2_sw,
  output logic [io_map_pkg::U410_BITS-1:0]     o_u410,
  output logic                                o_cmpr_latch,
  output logic [io_map_pkg::U902_BITS-1:0]     o_u902
);

  logic [reg_map_pkg::ADDR_WIDTH-1:0]     rd_addr, wr_addr;
  logic [reg_map_pkg::REG_WIDTH-1:0]      rd_data, wr_data;
  logic                                  wr_valid;
  logic                                  route_en;
  logic [io_map_pkg::MODE_BITS-1:0]       mode;
  logic [reg_map_pkg::REG_WIDTH-1:0]      direct, aperture;
  logic [reg_map_pkg::PRECHARGE_BITS-1:0] precharge;
  logic                                  pc_sw, pc_led;
  logic [io_map_pkg::MONITOR_BITS-1:0]    pc_monitor;
  logic [io_map_pkg::OUT_BITS-1:0]        word;

  spi_port u_spi_port (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_sck(i_sck), .i_sdi(i_sdi), .i_ss_n(i_ss_n), .i_cs2_n(i_cs2_n),
    .i_route_en(route_en), .i_4094_miso(i_4094_miso), .i_rd_data(rd_data),
    .o_sdo(o_sdo), .o_rd_addr(rd_addr),
    .o_wr_valid(wr_valid), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
    .o_4094_clk(o_4094_clk), .o_4094_data(o_4094_data), .o_4094_strobe(o_4094_strobe)
  );

  register_bank u_register_bank (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_wr_valid(wr_valid), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_addr(rd_addr), .i_hw_flags(i_hw_flags), .o_rd_data(rd_data),
    .o_mode(mode), .o_direct(direct), .o_4094_oe(o_4094_oe), .o_route_en(route_en),
    .o_aperture(aperture), .o_precharge(precharge)
  );

  precharge_sequencer u_precharge_sequencer (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_aperture(aperture), .i_precharge(precharge),
    .o_pc_sw(pc_sw), .o_led(pc_led), .o_monitor(pc_monitor)
  );

  output_mux u_output_mux (
    .clk(clk), .i_rst_n(i_rst_n), .i_mode(mode), .i_direct(direct),
    .i_pc_sw(pc_sw), .i_pc_led(pc_led), .i_pc_monitor(pc_monitor), .o_word(word)
  );

  ////////////////////
  // pin word split
  assign o_leds          = word[io_map_pkg::LEDS_LSB +: io_map_pkg::LEDS_BITS];
  assign o_monitor       = word[io_map_pkg::MONITOR_LSB +: io_map_pkg::MONITOR_BITS];
  assign o_spi_interrupt = word[io_map_pkg::SPI_INT_BIT];
  assign o_meas_complete = word[io_map_pkg::MEAS_DONE_BIT];
  assign o_sig_pc1_sw    = word[io_map_pkg::PC1_BIT];
  assign o_sig_pc2_sw    = word[io_map_pkg::PC2_BIT];
  assign o_u410          = word[io_map_pkg::U410_LSB +: io_map_pkg::U410_BITS];  // az mux
  assign o_cmpr_latch    = word[io_map_pkg::CMPR_LATCH_BIT];
  assign o_u902          = word[io_map_pkg::U902_LSB +: io_map_pkg::U902_BITS];  // ref mux

endmodule

// ==== tests/tb_meas_ctrl.sv ====
/* measurement control testbench
   replays the golden step file over spi, checks register reads,
   pin word, precharge timing, test pattern and 4094 pass-through
*/
`timescale 1ns/1ns

module tb_meas_ctrl;

  localparam int CLK_HALF   = 20;                  // 40 ns clk
  localparam int SCK_HALF   = 4;                   // clk per sck half period
  localparam int RST_CYCLES = 8;
  localparam int SEED       = 98273;

  logic clk;
  logic i_rst_n, i_sck, i_sdi, i_ss_n, i_cs2_n, i_4094_miso;
  logic [reg_map_pkg::HW_FLAG_BITS-1:0] i_hw_flags;
  logic o_sdo, o_4094_clk, o_4094_data, o_4094_strobe, o_4094_oe;
  logic [3:0] o_leds, o_u410, o_u902;
  logic [7:0] o_monitor;
  logic o_spi_interrupt, o_meas_complete, o_sig_pc1_sw, o_sig_pc2_sw, o_cmpr_latch;
  logic [io_map_pkg::OUT_BITS-1:0] pin_word;

  // one entry per golden file line
  string       op_q[$];
  logic [31:0] addr_q[$], data_q[$], exp_q[$];
  string       name_q[$];
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;                    // 0 until the file is read

  meas_ctrl_top dut (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_sck(i_sck), .i_sdi(i_sdi), .i_ss_n(i_ss_n), .i_cs2_n(i_cs2_n),
    .i_4094_miso(i_4094_miso), .i_hw_flags(i_hw_flags),
    .o_sdo(o_sdo), .o_4094_clk(o_4094_clk), .o_4094_data(o_4094_data),
    .o_4094_strobe(o_4094_strobe), .o_4094_oe(o_4094_oe),
    .o_leds(o_leds), .o_monitor(o_monitor), .o_spi_interrupt(o_spi_interrupt),
    .o_meas_complete(o_meas_complete), .o_sig_pc1_sw(o_sig_pc1_sw),
    .o_sig_pc2_sw(o_sig_pc2_sw), .o_u410(o_u410), .o_cmpr_latch(o_cmpr_latch),
    .o_u902(o_u902)
  );

  // pins back into one word with the msb field first
  assign pin_word = {o_u902, o_cmpr_latch, o_u410, o_sig_pc2_sw, o_sig_pc1_sw,
                     o_meas_complete, o_spi_interrupt, o_monitor, o_leds};

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////
  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("ERRORS FOUND");
      $fatal(1, "timeout, the run did not finish within %0d clock cycles", cycle_limit);
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("ERROR %s expected %h actual %h", name, exp_val, act_val);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch in step %s", name);
    end
  endtask

  task automatic load_steps();
    int          fd, cnt, max_sum;
    string       line, op, name;
    logic [31:0] a, d, e;
    fd = $fopen("tests/golden_frames.txt", "r");
    if (fd == 0)
    begin
      $display("ERRORS FOUND");
      $fatal(1, "could not open the golden step file");
    end
    max_sum = 0;
    while ($fgets(line, fd) > 0)
    begin
      cnt = $sscanf(line, "%s %h %h %h %s", op, a, d, e, name);
      if (cnt == 5)                                // comment and blank lines fall out here
      begin
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
        name_q.push_back(name);
        if (op == "P" && int'(d + e) > max_sum)
          max_sum = int'(d + e);                   // longest precharge cycle
      end
    end
    $fclose(fd);
    cycle_limit = op_q.size() * (reg_map_pkg::FRAME_BITS * 8 + 64) + 2 * max_sum;
  endtask

  ////////////////////
  // spi mode 0 master
  task automatic shift_frame(input logic [reg_map_pkg::FRAME_BITS-1:0] frame,
                             output logic [31:0] rdata);
    rdata = '0;
    @(posedge clk) i_ss_n <= 1'b0;
    repeat (SCK_HALF) @(posedge clk);
    for (int i = reg_map_pkg::FRAME_BITS - 1; i >= 0; i--)
    begin
      @(posedge clk);
      i_sck <= 1'b0;
      i_sdi <= frame[i];                           // setup while sck low
      repeat (SCK_HALF - 1) @(posedge clk);
      @(negedge clk);
      if (i < reg_map_pkg::REG_WIDTH)
        rdata[i] = o_sdo;                          // data phase msb first
      @(posedge clk) i_sck <= 1'b1;
      repeat (SCK_HALF - 1) @(posedge clk);
    end
    @(posedge clk) i_sck <= 1'b0;
    repeat (SCK_HALF) @(posedge clk);
    i_ss_n <= 1'b1;
    repeat (SCK_HALF) @(posedge clk);              // write lands in the bank here
  endtask

  task automatic wait_pc1_level(input logic lvl);
    @(negedge clk);
    while (o_sig_pc1_sw !== lvl)
      @(negedge clk);
  endtask

  task automatic measure_precharge_cycle(input string name, input logic [31:0] p,
                                         input logic [31:0] a);
    int          hi_len, lo_len;
    logic        led0, led_exp;
    logic [6:0]  cyc0, cyc_exp;
    logic [31:0] hi_exp, lo_exp;
    hi_exp = (p == 32'd0) ? 32'd1 : p;             // zero runs as one cycle
    lo_exp = (a == 32'd0) ? 32'd1 : a;
    wait_pc1_level(1'b0);
    wait_pc1_level(1'b1);                          // start of a precharge phase
    led0   = o_leds[0];
    cyc0   = o_monitor[6:0];
    hi_len = 0;
    while (o_sig_pc1_sw)
    begin
      hi_len++;
      @(negedge clk);
    end
    check_value({name, "_led_hold"}, {31'b0, led0}, {31'b0, o_leds[0]});
    lo_len = 0;
    while (!o_sig_pc1_sw)
    begin
      lo_len++;
      @(negedge clk);
    end
    led_exp = ~led0;                               // one toggle per full cycle
    cyc_exp = cyc0 + 7'd1;                         // wraps at 128
    check_value({name, "_high"}, hi_exp, 32'(hi_len));
    check_value({name, "_low"}, lo_exp, 32'(lo_len));
    check_value({name, "_led_toggle"}, {31'b0, led_exp}, {31'b0, o_leds[0]});
    check_value({name, "_cycle_count"}, {25'b0, cyc_exp}, {25'b0, o_monitor[6:0]});
  endtask

  task automatic follow_pattern_leds(input string name, input int samples);
    logic [3:0] prev, nxt;
    @(negedge clk);
    prev = o_leds;
    repeat (samples)
    begin
      @(negedge clk);
      nxt = prev + 4'd1;                           // wraps at 16
      check_value(name, {28'b0, nxt}, {28'b0, o_leds});
      prev = o_leds;
    end
  endtask

  // 4094 chain with miso driven as the inverse of sdi
  task automatic drive_4094_chain(input string name, input logic [31:0] bits,
                                  input logic [31:0] route);
    logic r;
    r = route[0];
    @(posedge clk) i_cs2_n <= 1'b0;
    repeat (SCK_HALF) @(posedge clk);
    for (int i = 7; i >= 0; i--)
    begin
      @(posedge clk);
      i_sck       <= 1'b0;
      i_sdi       <= bits[i];
      i_4094_miso <= ~bits[i];
      repeat (SCK_HALF - 1) @(posedge clk);
      @(negedge clk);
      check_value({name, "_sck_low"}, {28'b0, 1'b0, r & bits[i], r, r & ~bits[i]},
                  {28'b0, o_4094_clk, o_4094_data, o_4094_strobe, o_sdo});
      @(posedge clk) i_sck <= 1'b1;
      repeat (SCK_HALF - 1) @(posedge clk);
      @(negedge clk);
      check_value({name, "_sck_high"}, {28'b0, r, r & bits[i], r, r & ~bits[i]},
                  {28'b0, o_4094_clk, o_4094_data, o_4094_strobe, o_sdo});
    end
    @(posedge clk);
    i_sck       <= 1'b0;
    i_sdi       <= 1'b0;
    i_4094_miso <= 1'b0;
    repeat (SCK_HALF) @(posedge clk);
    i_cs2_n <= 1'b1;
    repeat (SCK_HALF) @(posedge clk);
    @(negedge clk);
    check_value({name, "_idle"}, 32'd0,
                {28'b0, o_4094_clk, o_4094_data, o_4094_strobe, o_sdo});
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    logic [31:0] rdata;
    logic [31:0] exp_val;
    i_rst_n     = 1'b0;
    i_sck       = 1'b0;
    i_sdi       = 1'b0;
    i_ss_n      = 1'b1;
    i_cs2_n     = 1'b1;
    i_4094_miso = 1'b0;
    void'($urandom(SEED));
    i_hw_flags = reg_map_pkg::HW_FLAG_BITS'($urandom());  // board flags for the run
    load_steps();
    repeat (RST_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    foreach (op_q[k])
    begin
      case (op_q[k])
        "W": shift_frame({1'b1, addr_q[k][reg_map_pkg::ADDR_WIDTH-1:0], data_q[k]}, rdata);
        "R":
        begin
          shift_frame({1'b0, addr_q[k][reg_map_pkg::ADDR_WIDTH-1:0], 32'h0}, rdata);
          exp_val = exp_q[k];
          if (addr_q[k][reg_map_pkg::ADDR_WIDTH-1:0] == reg_map_pkg::ADDR_STATUS)
            exp_val = exp_val | {21'b0, i_hw_flags, 8'h00};   // flags above magic
          check_value(name_q[k], exp_val, rdata);
        end
        "O":
        begin
          repeat (4) @(posedge clk);               // mux settles
          @(negedge clk);
          check_value({name_q[k], "_oe"}, data_q[k], {31'b0, o_4094_oe});
          check_value(name_q[k], exp_q[k], {7'b0, pin_word});
        end
        "P": measure_precharge_cycle(name_q[k], data_q[k], exp_q[k]);
        "T": follow_pattern_leds(name_q[k], int'(data_q[k]));
        "X": drive_4094_chain(name_q[k], data_q[k], exp_q[k]);
        default:
        begin
          $display("ERRORS FOUND");
          $fatal(1, "unknown operation in golden step %s", name_q[k]);
        end
      endcase
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== tests/golden_frames.txt ====
# op addr data expect name, fields in hex
# R status rows hold the magic byte only, flags are board inputs
# O data is the 4094 enable, P data precharge and expect aperture, T data is samples
O 00 00000000 00000000 reset_pins_low
R 00 00000000 000000AA status_magic
R 04 00000000 00000010 aperture_reset
R 05 00000000 00000008 precharge_reset
W 02 A5C3E7F1 00000000 direct_write
R 02 00000000 A5C3E7F1 direct_readback
O 00 00000000 01C3E7F1 mode0_direct_pins
W 01 FFFFFFF9 00000000 mode_write_wide
R 01 00000000 00000001 mode_truncated
O 00 00000000 00000000 mode1_zero_pins
W 01 00000002 00000000 mode_ones
O 00 00000000 01FFFFFF mode2_ones_pins
W 01 00000005 00000000 mode_unused
O 00 00000000 00000000 mode5_zero_pins
W 7F 12345678 00000000 unknown_write
R 7F 00000000 00000000 unknown_read
W 03 FFFFFFFF 00000000 oe_on
R 03 00000000 00000001 oe_readback
O 00 00000001 00000000 oe_on_pin
W 03 00000000 00000000 oe_off
O 00 00000000 00000000 oe_off_pin
W 01 00000003 00000000 mode_pattern
T 00 00000014 00000000 pattern_leds
W 05 FF000003 00000000 precharge_wide
R 05 00000000 00000003 precharge_truncated
W 04 00000007 00000000 aperture_write
R 04 00000000 00000007 aperture_readback
W 01 00000004 00000000 mode_precharge
P 00 00000003 00000007 pc_3_ap_7
W 05 00000000 00000000 precharge_zero
W 04 00000002 00000000 aperture_two
P 00 00000000 00000002 pc_0_ap_2
W 06 00000001 00000000 route_on
R 06 00000000 00000001 route_readback
X 00 000000B4 00000001 chain_routed
W 06 FFFFFFFE 00000000 route_off
X 00 0000005A 00000000 chain_blocked

// ==== sources.f ====
hw/reg_map_pkg.sv
hw/io_map_pkg.sv
hw/spi_port.sv
hw/register_bank.sv
hw/precharge_sequencer.sv
hw/output_mux.sv
hw/meas_ctrl_top.sv
tests/tb_meas_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the measurement control testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_meas_ctrl \
  -Mdir obj_dir -o tb_meas_ctrl
./obj_dir/tb_meas_ctrl
